/* src/rhythm_mem_pkg.sv */
package rhythm_mem_pkg;

	// memory port geometry
	localparam int ADDR_W = 22;
	localparam int DATA_W = 128;
	localparam int BE_W   = DATA_W / 8;

	// arbiter phases, boot first, then one pass per line until PCM
	typedef enum logic [7:0]
	{
		BOOTUP,
		INIT_SDRAM,
		INIT_SDRAM_DONE,
		INIT_MEMORY,
		INIT_MEMORY_DONE,
		LB_PRE_BK,
		LB_PRE_SP,
		LB_FETCH,
		LB_MID,
		LB_DONE,
		BACKGROUND,
		SCORE,
		PCM,
		PCM_DONE,
		HALTED,
		DONE
	} arb_phase_t;

endpackage

/* src/raster_timer.sv */
module raster_timer #(
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525
) (
	input  logic       clk,
	input  logic       reset,
	output logic [9:0] draw_x_o,
	output logic [9:0] draw_y_o,
	output logic       new_frame_o
);

	localparam logic [9:0] X_LAST = 10'(H_TOTAL - 1);
	localparam logic [9:0] Y_LAST = 10'(V_TOTAL - 1);

	logic line_end;
	logic frame_end;

	assign line_end  = (draw_x_o == X_LAST);
	assign frame_end = line_end && (draw_y_o == Y_LAST);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			draw_x_o    <= '0;
			draw_y_o    <= '0;
			new_frame_o <= 1'b0;
		end
		else
		begin
			// high while both counters sit at zero after the wrap
			new_frame_o <= frame_end;
			if (line_end)
			begin
				draw_x_o <= '0;
				if (frame_end)
					draw_y_o <= '0;
				else
					draw_y_o <= draw_y_o + 10'd1;
			end
			else
				draw_x_o <= draw_x_o + 10'd1;
		end
	end

endmodule

/* src/word_mem.sv */
module word_mem #(
	parameter int MEM_WORDS   = 1024,
	parameter int ACK_LATENCY = 3
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   ar_addr_i,
	input  logic [rhythm_mem_pkg::BE_W-1:0]     ar_be_i,
	input  logic                                ar_read_i,
	input  logic                                ar_write_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   ar_wrdata_i,
	output logic                                ar_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   ar_rddata_o
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = (ACK_LATENCY > 1) ? $clog2(ACK_LATENCY) : 1;

	logic [rhythm_mem_pkg::DATA_W-1:0] mem [MEM_WORDS];
	logic [CNT_W-1:0]                  lat_cnt;
	logic [IDX_W-1:0]                  idx;
	logic                              req;
	logic                              fire;

	assign idx  = ar_addr_i[IDX_W-1:0];
	assign req  = ar_read_i || ar_write_i;
	// no new ack while the previous one is still on the port
	assign fire = req && !ar_ac_o && (lat_cnt == CNT_W'(ACK_LATENCY - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ar_ac_o <= 1'b0;
			lat_cnt <= '0;
		end
		else
		begin
			ar_ac_o <= fire;
			if (!req || ar_ac_o || fire)
				lat_cnt <= '0;
			else
				lat_cnt <= lat_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			ar_rddata_o <= mem[idx];
			if (ar_write_i)
			begin
				for (int b = 0; b < rhythm_mem_pkg::BE_W; b++)
					if (ar_be_i[b])
						mem[idx][b*8 +: 8] <= ar_wrdata_i[b*8 +: 8];
			end
		end
	end

endmodule

/* src/sdram_arbiter.sv */
module sdram_arbiter #(
	parameter int H_TOTAL = 800
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                new_frame_i,
	input  logic [9:0]                          draw_x_i,
	input  logic                                stop_sign_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   init_addr_i,
	input  logic                                init_we_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   init_wrdata_i,
	input  logic                                init_done_i,
	output logic                                init_ac_o,
	output logic                                init_wait_o,
	input  logic                                mem_init_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   mem_init_addr_i,
	input  logic                                mem_init_done_i,
	output logic                                mem_init_wait_o,
	output logic                                mem_init_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   mem_init_data_o,
	input  logic                                lb_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   lb_addr_i,
	input  logic                                lb_busy_i,
	input  logic                                lb_done_i,
	output logic                                lb_wait_o,
	output logic                                lb_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   lb_data_o,
	input  logic                                bk_rd_i,
	input  logic                                bk_wr_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   bk_addr_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   bk_wrdata_i,
	input  logic                                bk_busy_i,
	input  logic                                bk_writedone_i,
	output logic                                bk_wait_o,
	output logic                                bk_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   bk_rddata_o,
	input  logic                                ds_wr_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   ds_addr_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   ds_wrdata_i,
	input  logic [rhythm_mem_pkg::BE_W-1:0]     ds_be_i,
	input  logic                                ds_busy_i,
	input  logic                                ds_done_i,
	output logic                                ds_wait_o,
	output logic                                ds_ac_o,
	input  logic                                i2s_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   i2s_addr_i,
	input  logic                                i2s_done_i,
	output logic                                i2s_wait_o,
	output logic                                i2s_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   i2s_data_o,
	output logic [rhythm_mem_pkg::ADDR_W-1:0]   ar_addr_o,
	output logic [rhythm_mem_pkg::BE_W-1:0]     ar_be_o,
	output logic                                ar_read_o,
	output logic                                ar_write_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   ar_wrdata_o,
	input  logic                                ar_ac_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   ar_rddata_i
);

	// raster points where the line buffer takes the port back
	localparam logic [9:0] X_FETCH = 10'(H_TOTAL - 1);
	localparam logic [9:0] X_BK_END = 10'(H_TOTAL - 15);
	localparam logic [9:0] X_DS_END = 10'(H_TOTAL - 30);

	rhythm_mem_pkg::arb_phase_t phase;
	rhythm_mem_pkg::arb_phase_t next_phase;

	always_ff @(posedge clk)
	begin
		if (reset)
			phase <= rhythm_mem_pkg::BOOTUP;
		else
			phase <= next_phase;
	end

	always_comb
	begin
		next_phase = phase;
		case (phase)
			rhythm_mem_pkg::BOOTUP:
				if (new_frame_i)
					next_phase = rhythm_mem_pkg::INIT_SDRAM;
			rhythm_mem_pkg::INIT_SDRAM:
				if (init_done_i)
					next_phase = rhythm_mem_pkg::INIT_SDRAM_DONE;
			rhythm_mem_pkg::INIT_SDRAM_DONE:
				next_phase = rhythm_mem_pkg::INIT_MEMORY;
			rhythm_mem_pkg::INIT_MEMORY:
				if (mem_init_done_i)
					next_phase = rhythm_mem_pkg::INIT_MEMORY_DONE;
			rhythm_mem_pkg::INIT_MEMORY_DONE:
				if (new_frame_i)
					next_phase = rhythm_mem_pkg::LB_PRE_BK;
			rhythm_mem_pkg::LB_PRE_BK:
				if (!bk_busy_i && draw_x_i == X_FETCH)
					next_phase = rhythm_mem_pkg::LB_FETCH;
			rhythm_mem_pkg::LB_PRE_SP:
				if (!ds_busy_i && draw_x_i == X_FETCH)
					next_phase = rhythm_mem_pkg::LB_FETCH;
			rhythm_mem_pkg::LB_FETCH:
				if (lb_done_i)
					next_phase = rhythm_mem_pkg::LB_DONE;
				else if (!lb_busy_i)
					next_phase = rhythm_mem_pkg::LB_MID;
			rhythm_mem_pkg::LB_MID:
				if (!bk_writedone_i)
					next_phase = rhythm_mem_pkg::BACKGROUND;
				else if (!ds_done_i)
					next_phase = rhythm_mem_pkg::SCORE;
				else if (draw_x_i == X_BK_END)
					next_phase = rhythm_mem_pkg::LB_PRE_BK;
			rhythm_mem_pkg::LB_DONE:
				if (!bk_writedone_i)
					next_phase = rhythm_mem_pkg::BACKGROUND;
				else if (!ds_done_i)
					next_phase = rhythm_mem_pkg::SCORE;
				else
					next_phase = rhythm_mem_pkg::PCM;
			rhythm_mem_pkg::BACKGROUND:
				if (lb_done_i)
				begin
					if (bk_writedone_i)
						next_phase = rhythm_mem_pkg::SCORE;
				end
				else if (draw_x_i == X_BK_END)
					next_phase = rhythm_mem_pkg::LB_PRE_BK;
			rhythm_mem_pkg::SCORE:
				if (lb_done_i)
				begin
					if (ds_done_i)
						next_phase = rhythm_mem_pkg::PCM;
				end
				else if (draw_x_i == X_DS_END)
					next_phase = rhythm_mem_pkg::LB_PRE_SP;
			rhythm_mem_pkg::PCM:
				if (i2s_done_i)
					next_phase = rhythm_mem_pkg::PCM_DONE;
			rhythm_mem_pkg::PCM_DONE:
				next_phase = rhythm_mem_pkg::HALTED;
			rhythm_mem_pkg::HALTED:
				if (stop_sign_i)
					next_phase = rhythm_mem_pkg::DONE;
				else if (new_frame_i)
					next_phase = rhythm_mem_pkg::LB_PRE_BK;
			default:
				next_phase = phase;
		endcase
	end

	// port mux, the pre phases let a client finish its in-flight request
	always_comb
	begin
		init_ac_o       = 1'b0;
		init_wait_o     = 1'b0;
		mem_init_wait_o = 1'b1;
		mem_init_ac_o   = 1'b0;
		mem_init_data_o = '0;
		lb_wait_o       = 1'b1;
		lb_ac_o         = 1'b0;
		lb_data_o       = '0;
		bk_wait_o       = 1'b1;
		bk_ac_o         = 1'b0;
		bk_rddata_o     = '0;
		ds_wait_o       = 1'b1;
		ds_ac_o         = 1'b0;
		i2s_wait_o      = 1'b1;
		i2s_ac_o        = 1'b0;
		i2s_data_o      = '0;
		ar_addr_o       = '0;
		ar_be_o         = '1;
		ar_read_o       = 1'b0;
		ar_write_o      = 1'b0;
		ar_wrdata_o     = '0;
		case (phase)
			rhythm_mem_pkg::BOOTUP,
			rhythm_mem_pkg::DONE:
				init_wait_o = 1'b1;
			rhythm_mem_pkg::INIT_SDRAM:
			begin
				init_ac_o   = ar_ac_i;
				ar_addr_o   = init_addr_i;
				ar_write_o  = init_we_i;
				ar_wrdata_o = init_wrdata_i;
			end
			rhythm_mem_pkg::INIT_SDRAM_DONE,
			rhythm_mem_pkg::INIT_MEMORY:
			begin
				mem_init_wait_o = (phase != rhythm_mem_pkg::INIT_MEMORY);
				mem_init_ac_o   = ar_ac_i;
				mem_init_data_o = ar_rddata_i;
				ar_addr_o       = mem_init_addr_i;
				ar_read_o       = mem_init_rd_i;
			end
			rhythm_mem_pkg::LB_FETCH:
			begin
				lb_wait_o = 1'b0;
				lb_ac_o   = ar_ac_i;
				lb_data_o = ar_rddata_i;
				ar_addr_o = lb_addr_i;
				ar_read_o = lb_rd_i;
			end
			rhythm_mem_pkg::BACKGROUND,
			rhythm_mem_pkg::LB_PRE_BK:
			begin
				bk_wait_o   = (phase != rhythm_mem_pkg::BACKGROUND);
				bk_ac_o     = ar_ac_i;
				bk_rddata_o = ar_rddata_i;
				ar_addr_o   = bk_addr_i;
				ar_read_o   = bk_rd_i;
				ar_write_o  = bk_wr_i;
				ar_wrdata_o = bk_wrdata_i;
			end
			rhythm_mem_pkg::SCORE,
			rhythm_mem_pkg::LB_PRE_SP:
			begin
				ds_wait_o   = (phase != rhythm_mem_pkg::SCORE);
				ds_ac_o     = ar_ac_i;
				ar_addr_o   = ds_addr_i;
				ar_be_o     = ds_be_i;
				ar_write_o  = ds_wr_i;
				ar_wrdata_o = ds_wrdata_i;
			end
			rhythm_mem_pkg::PCM:
			begin
				i2s_wait_o = 1'b0;
				i2s_ac_o   = ar_ac_i;
				i2s_data_o = ar_rddata_i;
				ar_addr_o  = i2s_addr_i;
				ar_read_o  = i2s_rd_i;
			end
			default:
				init_wait_o = 1'b0;
		endcase
	end

endmodule

/* src/rhythm_mem_top.sv */
module rhythm_mem_top #(
	parameter int H_TOTAL     = 800,
	parameter int V_TOTAL     = 525,
	parameter int MEM_WORDS   = 1024,
	parameter int ACK_LATENCY = 3
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                stop_sign_i,
	output logic [9:0]                          draw_x_o,
	output logic [9:0]                          draw_y_o,
	output logic                                new_frame_o,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   init_addr_i,
	input  logic                                init_we_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   init_wrdata_i,
	input  logic                                init_done_i,
	output logic                                init_ac_o,
	output logic                                init_wait_o,
	input  logic                                mem_init_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   mem_init_addr_i,
	input  logic                                mem_init_done_i,
	output logic                                mem_init_wait_o,
	output logic                                mem_init_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   mem_init_data_o,
	input  logic                                lb_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   lb_addr_i,
	input  logic                                lb_busy_i,
	input  logic                                lb_done_i,
	output logic                                lb_wait_o,
	output logic                                lb_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   lb_data_o,
	input  logic                                bk_rd_i,
	input  logic                                bk_wr_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   bk_addr_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   bk_wrdata_i,
	input  logic                                bk_busy_i,
	input  logic                                bk_writedone_i,
	output logic                                bk_wait_o,
	output logic                                bk_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   bk_rddata_o,
	input  logic                                ds_wr_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   ds_addr_i,
	input  logic [rhythm_mem_pkg::DATA_W-1:0]   ds_wrdata_i,
	input  logic [rhythm_mem_pkg::BE_W-1:0]     ds_be_i,
	input  logic                                ds_busy_i,
	input  logic                                ds_done_i,
	output logic                                ds_wait_o,
	output logic                                ds_ac_o,
	input  logic                                i2s_rd_i,
	input  logic [rhythm_mem_pkg::ADDR_W-1:0]   i2s_addr_i,
	input  logic                                i2s_done_i,
	output logic                                i2s_wait_o,
	output logic                                i2s_ac_o,
	output logic [rhythm_mem_pkg::DATA_W-1:0]   i2s_data_o
);

	// arbitrated memory port
	logic [rhythm_mem_pkg::ADDR_W-1:0] ar_addr;
	logic [rhythm_mem_pkg::BE_W-1:0]   ar_be;
	logic                              ar_read;
	logic                              ar_write;
	logic [rhythm_mem_pkg::DATA_W-1:0] ar_wrdata;
	logic                              ar_ac;
	logic [rhythm_mem_pkg::DATA_W-1:0] ar_rddata;

	raster_timer #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL)
	) raster_timer_i (
		.clk(clk),
		.reset(reset),
		.draw_x_o(draw_x_o),
		.draw_y_o(draw_y_o),
		.new_frame_o(new_frame_o)
	);

	sdram_arbiter #(
		.H_TOTAL(H_TOTAL)
	) sdram_arbiter_i (
		.clk(clk),
		.reset(reset),
		.new_frame_i(new_frame_o),
		.draw_x_i(draw_x_o),
		.stop_sign_i(stop_sign_i),
		.init_addr_i(init_addr_i),
		.init_we_i(init_we_i),
		.init_wrdata_i(init_wrdata_i),
		.init_done_i(init_done_i),
		.init_ac_o(init_ac_o),
		.init_wait_o(init_wait_o),
		.mem_init_rd_i(mem_init_rd_i),
		.mem_init_addr_i(mem_init_addr_i),
		.mem_init_done_i(mem_init_done_i),
		.mem_init_wait_o(mem_init_wait_o),
		.mem_init_ac_o(mem_init_ac_o),
		.mem_init_data_o(mem_init_data_o),
		.lb_rd_i(lb_rd_i),
		.lb_addr_i(lb_addr_i),
		.lb_busy_i(lb_busy_i),
		.lb_done_i(lb_done_i),
		.lb_wait_o(lb_wait_o),
		.lb_ac_o(lb_ac_o),
		.lb_data_o(lb_data_o),
		.bk_rd_i(bk_rd_i),
		.bk_wr_i(bk_wr_i),
		.bk_addr_i(bk_addr_i),
		.bk_wrdata_i(bk_wrdata_i),
		.bk_busy_i(bk_busy_i),
		.bk_writedone_i(bk_writedone_i),
		.bk_wait_o(bk_wait_o),
		.bk_ac_o(bk_ac_o),
		.bk_rddata_o(bk_rddata_o),
		.ds_wr_i(ds_wr_i),
		.ds_addr_i(ds_addr_i),
		.ds_wrdata_i(ds_wrdata_i),
		.ds_be_i(ds_be_i),
		.ds_busy_i(ds_busy_i),
		.ds_done_i(ds_done_i),
		.ds_wait_o(ds_wait_o),
		.ds_ac_o(ds_ac_o),
		.i2s_rd_i(i2s_rd_i),
		.i2s_addr_i(i2s_addr_i),
		.i2s_done_i(i2s_done_i),
		.i2s_wait_o(i2s_wait_o),
		.i2s_ac_o(i2s_ac_o),
		.i2s_data_o(i2s_data_o),
		.ar_addr_o(ar_addr),
		.ar_be_o(ar_be),
		.ar_read_o(ar_read),
		.ar_write_o(ar_write),
		.ar_wrdata_o(ar_wrdata),
		.ar_ac_i(ar_ac),
		.ar_rddata_i(ar_rddata)
	);

	word_mem #(
		.MEM_WORDS(MEM_WORDS),
		.ACK_LATENCY(ACK_LATENCY)
	) word_mem_i (
		.clk(clk),
		.reset(reset),
		.ar_addr_i(ar_addr),
		.ar_be_i(ar_be),
		.ar_read_i(ar_read),
		.ar_write_i(ar_write),
		.ar_wrdata_i(ar_wrdata),
		.ar_ac_o(ar_ac),
		.ar_rddata_o(ar_rddata)
	);

endmodule

/* tb/rhythm_mem_checker.sv */
module rhythm_mem_checker (
	input logic clk,
	input logic reset,
	input logic ar_read_i,
	input logic ar_write_i,
	input logic ar_ac_i,
	input logic [5:0] ack_i,
	input logic [5:0] wait_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// one direction on the memory port at a time
	rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(ar_read_i && ar_write_i))
		else $error("read and write requested together");

	one_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(ack_i))
		else $error("more than one client acknowledged");

	ack_from_mem: assert property (@(posedge clk) disable iff (reset) (|ack_i) |-> ar_ac_i)
		else $error("client ack without memory ack");

	waits_after_reset: assert property (@(posedge clk) reset |=> (&wait_i))
		else $error("wait output low right after reset");

endmodule

bind sdram_arbiter rhythm_mem_checker checker_i (
	.clk(clk),
	.reset(reset),
	.ar_read_i(ar_read_o),
	.ar_write_i(ar_write_o),
	.ar_ac_i(ar_ac_i),
	.ack_i({init_ac_o, mem_init_ac_o, lb_ac_o, bk_ac_o, ds_ac_o, i2s_ac_o}),
	.wait_i({init_wait_o, mem_init_wait_o, lb_wait_o, bk_wait_o, ds_wait_o, i2s_wait_o})
);

/* tb/rhythm_mem_tb.sv */
module rhythm_mem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_TOTAL = 64;
	localparam int V_TOTAL = 6;
	localparam int MEM_WORDS = 64;
	localparam int ACK_LATENCY = 3;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int LIMIT = 12 * FRAME;
	localparam int C_INIT = 0;
	localparam int C_MEMINIT = 1;
	localparam int C_LB = 2;
	localparam int C_BK = 3;
	localparam int C_DS = 4;
	localparam int C_I2S = 5;

	logic clk;
	logic reset;
	logic stop_sign_i;
	logic [9:0] draw_x_o;
	logic [9:0] draw_y_o;
	logic new_frame_o;
	logic [21:0] init_addr_i, mem_init_addr_i, lb_addr_i, bk_addr_i, ds_addr_i, i2s_addr_i;
	logic init_we_i, init_done_i, init_ac_o, init_wait_o;
	logic mem_init_rd_i, mem_init_done_i, mem_init_wait_o, mem_init_ac_o;
	logic lb_rd_i, lb_busy_i, lb_done_i, lb_wait_o, lb_ac_o;
	logic bk_rd_i, bk_wr_i, bk_busy_i, bk_writedone_i, bk_wait_o, bk_ac_o;
	logic ds_wr_i, ds_busy_i, ds_done_i, ds_wait_o, ds_ac_o;
	logic i2s_rd_i, i2s_done_i, i2s_wait_o, i2s_ac_o;
	logic [127:0] init_wrdata_i, bk_wrdata_i, ds_wrdata_i;
	logic [127:0] mem_init_data_o, lb_data_o, bk_rddata_o, i2s_data_o;
	logic [15:0] ds_be_i;

	logic [127:0] ref_mem [MEM_WORDS];
	logic [31:0] lfsr;
	int errors;
	int cycles;

	rhythm_mem_top #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL),
		.MEM_WORDS(MEM_WORDS),
		.ACK_LATENCY(ACK_LATENCY)
	) dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic step_lfsr();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [127:0] random_word();
		logic [127:0] w;
		for (int i = 0; i < 128; i++)
			w[i] = step_lfsr();
		return w;
	endfunction

	function automatic logic wait_of(input int c);
		case (c)
			C_INIT: return init_wait_o;
			C_MEMINIT: return mem_init_wait_o;
			C_LB: return lb_wait_o;
			C_BK: return bk_wait_o;
			C_DS: return ds_wait_o;
			default: return i2s_wait_o;
		endcase
	endfunction

	function automatic logic ack_of(input int c);
		case (c)
			C_INIT: return init_ac_o;
			C_MEMINIT: return mem_init_ac_o;
			C_LB: return lb_ac_o;
			C_BK: return bk_ac_o;
			C_DS: return ds_ac_o;
			default: return i2s_ac_o;
		endcase
	endfunction

	function automatic logic [127:0] data_of(input int c);
		case (c)
			C_MEMINIT: return mem_init_data_o;
			C_LB: return lb_data_o;
			C_BK: return bk_rddata_o;
			C_I2S: return i2s_data_o;
			default: return '0;
		endcase
	endfunction

	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
		if (got !== exp)
		begin
			$display("error %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic drive_client(input int c, input bit on, input bit wr, input logic [21:0] addr,
		input logic [127:0] wdata, input logic [15:0] be);
		case (c)
			C_INIT:
			begin
				init_we_i = on;
				init_addr_i = addr;
				init_wrdata_i = wdata;
			end
			C_MEMINIT:
			begin
				mem_init_rd_i = on;
				mem_init_addr_i = addr;
			end
			C_LB:
			begin
				lb_rd_i = on;
				lb_addr_i = addr;
			end
			C_BK:
			begin
				bk_rd_i = on && !wr;
				bk_wr_i = on && wr;
				bk_addr_i = addr;
				bk_wrdata_i = wdata;
			end
			C_DS:
			begin
				ds_wr_i = on;
				ds_addr_i = addr;
				ds_wrdata_i = wdata;
				ds_be_i = be;
			end
			default:
			begin
				i2s_rd_i = on;
				i2s_addr_i = addr;
			end
		endcase
	endtask

	// called 2 ns after an edge and returns at the same point
	task automatic request(input int c, input bit wr, input logic [21:0] addr,
		input logic [127:0] wdata, input logic [15:0] be, output logic [127:0] rdata);
		int n;
		bit got;
		n = 0;
		got = 0;
		rdata = '0;
		drive_client(c, 1'b1, wr, addr, wdata, be);
		while (!got && n < ACK_LATENCY + 4)
		begin
			@(posedge clk);
			#1;
			n++;
			if (ack_of(c))
			begin
				got = 1;
				rdata = data_of(c);
			end
		end
		#1;
		drive_client(c, 1'b0, 1'b0, '0, '0, '0);
		if (!got)
		begin
			$display("client %0d got no acknowledge for address %0d at %0t", c, addr, $time);
			errors++;
		end
	endtask

	task automatic wait_grant(input int c);
		int n;
		n = 0;
		while (wait_of(c) && n <= 2 * FRAME)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (wait_of(c))
		begin
			$display("client %0d was never granted the port", c);
			errors++;
		end
	endtask

	task automatic wait_frame();
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!new_frame_o);
		#1;
		// both counters wrap together on the frame pulse
		check_eq(128'(draw_x_o), 128'h0, "draw_x on frame pulse");
		check_eq(128'(draw_y_o), 128'h0, "draw_y on frame pulse");
	endtask

	task automatic write_word(input int c, input int a, input logic [127:0] w,
		input logic [15:0] be);
		logic [127:0] dummy;
		request(c, 1'b1, 22'(a), w, be, dummy);
		for (int b = 0; b < 16; b++)
			if (be[b])
				ref_mem[a][b*8 +: 8] = w[b*8 +: 8];
	endtask

	task automatic read_check(input int c, input int a);
		logic [127:0] d;
		request(c, 1'b0, 22'(a), '0, '0, d);
		check_eq(d, ref_mem[a], $sformatf("client %0d read of word %0d", c, a));
	endtask

	task automatic test_reset();
		check_eq(128'({init_wait_o, mem_init_wait_o, lb_wait_o, bk_wait_o, ds_wait_o,
			i2s_wait_o}), 128'h3f, "wait outputs after reset");
		check_eq(128'({init_ac_o, mem_init_ac_o, lb_ac_o, bk_ac_o, ds_ac_o, i2s_ac_o}),
			128'h0, "acks after reset");
	endtask

	task automatic test_boot();
		wait_frame();
		wait_grant(C_INIT);
		for (int a = 0; a < 16; a++)
			write_word(C_INIT, a, random_word(), 16'hffff);
		init_done_i = 1'b1;
		wait_grant(C_MEMINIT);
		init_done_i = 1'b0;
		for (int a = 0; a < 16; a++)
			read_check(C_MEMINIT, a);
		mem_init_done_i = 1'b1;
	endtask

	task automatic test_line();
		lb_busy_i = 1'b1;
		wait_grant(C_LB);
		// fetch opens once draw_x has wrapped at the end of the first line
		check_eq(128'(draw_x_o), 128'h0, "draw_x at line buffer grant");
		check_eq(128'(draw_y_o), 128'h1, "draw_y at line buffer grant");
		mem_init_done_i = 1'b0;
		for (int a = 0; a < 4; a++)
			read_check(C_LB, a);
		lb_busy_i = 1'b0;
		wait_grant(C_BK);
		lb_busy_i = 1'b1;
		for (int a = 0; a < 4; a++)
			write_word(C_BK, a, random_word(), 16'hffff);
		read_check(C_BK, 0);
		wait_grant(C_LB);
		for (int a = 0; a < 4; a++)
			read_check(C_LB, a);
	endtask

	task automatic test_score();
		bk_writedone_i = 1'b1;
		lb_busy_i = 1'b0;
		wait_grant(C_DS);
		lb_busy_i = 1'b1;
		write_word(C_DS, 4, random_word(), 16'h00ff);
		write_word(C_DS, 5, random_word(), 16'ha5c3);
		wait_grant(C_LB);
		read_check(C_LB, 4);
		read_check(C_LB, 5);
	endtask

	task automatic test_pcm_end();
		int n;
		ds_done_i = 1'b1;
		lb_done_i = 1'b1;
		wait_grant(C_I2S);
		for (int a = 6; a < 10; a++)
			read_check(C_I2S, a);
		read_check(C_I2S, 0);
		i2s_done_i = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		check_eq(128'(i2s_wait_o), 128'h1, "i2s wait after pcm done");
		stop_sign_i = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		check_eq(128'(init_wait_o), 128'h1, "init wait in done phase");
		// frame period while done holds across frames
		wait_frame();
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (!new_frame_o);
		check_eq(128'(n), 128'(FRAME), "cycles between frame pulses");
		repeat (3) @(posedge clk);
		#2;
		check_eq(128'(init_wait_o), 128'h1, "init wait on a later frame");
	endtask

	initial
	begin
		lfsr = 32'h96ef509f;
		errors = 0;
		cycles = 0;
		reset = 1'b1;
		stop_sign_i = 1'b0;
		init_done_i = 1'b0;
		mem_init_done_i = 1'b0;
		lb_busy_i = 1'b0;
		lb_done_i = 1'b0;
		bk_busy_i = 1'b0;
		bk_writedone_i = 1'b0;
		ds_busy_i = 1'b0;
		ds_done_i = 1'b0;
		i2s_done_i = 1'b0;
		for (int c = 0; c < 6; c++)
			drive_client(c, 1'b0, 1'b0, '0, '0, '0);
		for (int a = 0; a < MEM_WORDS; a++)
			ref_mem[a] = 'x;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		@(posedge clk);
		#1;
		test_reset();
		#1;
		test_boot();
		test_line();
		test_score();
		test_pcm_end();
		$display("errors: %0d after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* rhythm_mem.f */
src/rhythm_mem_pkg.sv
src/raster_timer.sv
src/word_mem.sv
src/sdram_arbiter.sv
src/rhythm_mem_top.sv
tb/rhythm_mem_checker.sv
tb/rhythm_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rhythm_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rhythm_mem.f --top-module rhythm_mem_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vrhythm_mem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
	exit 0
fi
exit 1
